//--- hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // *******************************************************************
  // Widths
  // *******************************************************************
  localparam int DATA_W   = 32;
  localparam int REG_W    = 5;
  localparam int LINK_REG = 31;  // Return address register of jal

  // *******************************************************************
  // Encodings
  // *******************************************************************
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBne   = 6'h05,
    opXori  = 6'h0E,
    opLw    = 6'h23,
    opSw    = 6'h2B
  } opcodeT;

  // Function field, only looked at when the opcode is R-type
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnSlt = 6'h2A
  } functT;

  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluSlt,
    aluXor
  } aluOpT;

endpackage

`default_nettype wire

//--- hw/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      instrValid,
  input  logic [31:0]               instr,
  input  logic [31:0]               pc,
  output logic                      decValid,
  output logic                      regWrite,
  output logic                      memToReg,
  output logic                      memWrite,
  output logic                      branch,
  output logic                      jump,
  output logic                      jumpReg,
  output logic                      link,
  output logic                      aluSrc,
  output logic                      zeroExt,
  output mipsPkg::aluOpT            aluControl,
  output logic [mipsPkg::REG_W-1:0] rs,
  output logic [mipsPkg::REG_W-1:0] rt,
  output logic [mipsPkg::REG_W-1:0] destReg,
  output logic [15:0]               imm,
  output logic [25:0]               target,
  output logic [31:0]               decPc
);
  import mipsPkg::*;

  opcodeT           op;
  functT            funct;
  logic             regWriteC;
  logic             memToRegC;
  logic             memWriteC;
  logic             branchC;
  logic             jumpC;
  logic             jumpRegC;
  logic             linkC;
  logic             aluSrcC;
  logic             zeroExtC;
  logic             regDstC;
  aluOpT            aluOpC;
  logic [REG_W-1:0] destC;

  assign op    = opcodeT'(instr[31:26]);
  assign funct = functT'(instr[5:0]);

  // Anything not listed leaves every control low and retires as a no-op
  always_comb begin
    regWriteC = 1'b0;
    memToRegC = 1'b0;
    memWriteC = 1'b0;
    branchC   = 1'b0;
    jumpC     = 1'b0;
    jumpRegC  = 1'b0;
    linkC     = 1'b0;
    aluSrcC   = 1'b0;
    zeroExtC  = 1'b0;
    regDstC   = 1'b0;
    aluOpC    = aluAdd;
    if (instrValid) begin
      case (op)
        opRtype: begin
          case (funct)
            fnJr: jumpRegC = 1'b1;
            fnAdd, fnSub, fnSlt: begin
              regWriteC = 1'b1;
              regDstC   = 1'b1;
              aluOpC    = (funct == fnAdd) ? aluAdd :
                          (funct == fnSub) ? aluSub : aluSlt;
            end
            default: ;
          endcase
        end
        opJ:   jumpC = 1'b1;
        opJal: begin
          jumpC     = 1'b1;
          linkC     = 1'b1;
          regWriteC = 1'b1;
        end
        opBne: begin
          branchC = 1'b1;
          aluOpC  = aluSub;
        end
        opXori: begin
          regWriteC = 1'b1;
          aluSrcC   = 1'b1;
          zeroExtC  = 1'b1;
          aluOpC    = aluXor;
        end
        opLw: begin
          regWriteC = 1'b1;
          memToRegC = 1'b1;
          aluSrcC   = 1'b1;
        end
        opSw: begin
          memWriteC = 1'b1;
          aluSrcC   = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign destC = linkC   ? REG_W'(LINK_REG) :
                 regDstC ? instr[15:11] : instr[20:16];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid   <= 1'b0;
      regWrite   <= 1'b0;
      memToReg   <= 1'b0;
      memWrite   <= 1'b0;
      branch     <= 1'b0;
      jump       <= 1'b0;
      jumpReg    <= 1'b0;
      link       <= 1'b0;
      aluSrc     <= 1'b0;
      zeroExt    <= 1'b0;
      aluControl <= aluAdd;
    end else begin
      decValid   <= instrValid;
      regWrite   <= regWriteC;
      memToReg   <= memToRegC;
      memWrite   <= memWriteC;
      branch     <= branchC;
      jump       <= jumpC;
      jumpReg    <= jumpRegC;
      link       <= linkC;
      aluSrc     <= aluSrcC;
      zeroExt    <= zeroExtC;
      aluControl <= aluOpC;
    end
  end

  // Instruction fields
  always_ff @(posedge clk) begin
    rs      <= instr[25:21];
    rt      <= instr[20:16];
    destReg <= destC;
    imm     <= instr[15:0];
    target  <= instr[25:0];
    decPc   <= pc;
  end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [mipsPkg::REG_W-1:0]  rdAddrA,
  input  logic [mipsPkg::REG_W-1:0]  rdAddrB,
  input  logic                       wrEn,
  input  logic [mipsPkg::REG_W-1:0]  wrAddr,
  input  logic [mipsPkg::DATA_W-1:0] wrData,
  output logic [mipsPkg::DATA_W-1:0] rdDataA,
  output logic [mipsPkg::DATA_W-1:0] rdDataB
);
  import mipsPkg::*;

  localparam int NUM_REGS = 2 ** REG_W;

  logic [DATA_W-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin  // Register zero never changes
      regs[wrAddr] <= wrData;
    end
  end

  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- hw/dataMem.sv
`timescale 1ns/1ns
`default_nettype none

module dataMem #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(DMEM_WORDS)-1:0] addr,    // Word index
  input  logic [mipsPkg::DATA_W-1:0]    wrData,
  output logic [mipsPkg::DATA_W-1:0]    rdData
);
  import mipsPkg::*;

  logic [DATA_W-1:0] mem [DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wrData;
    end
  end

  // Read is combinational so a load sees a store from the previous cycle
  assign rdData = mem[addr];

endmodule

`default_nettype wire

//--- hw/executeUnit.sv
`timescale 1ns/1ns
`default_nettype none

module executeUnit #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       decValid,
  input  logic                       regWrite,
  input  logic                       memToReg,
  input  logic                       memWrite,
  input  logic                       branch,
  input  logic                       jump,
  input  logic                       jumpReg,
  input  logic                       link,
  input  logic                       aluSrc,
  input  logic                       zeroExt,
  input  mipsPkg::aluOpT             aluControl,
  input  logic [mipsPkg::REG_W-1:0]  rs,
  input  logic [mipsPkg::REG_W-1:0]  rt,
  input  logic [mipsPkg::REG_W-1:0]  destReg,
  input  logic [15:0]                imm,
  input  logic [25:0]                target,
  input  logic [31:0]                decPc,
  input  logic [mipsPkg::DATA_W-1:0] rdDataA,
  input  logic [mipsPkg::DATA_W-1:0] rdDataB,
  input  logic                       fwdEn,
  input  logic [mipsPkg::REG_W-1:0]  fwdReg,
  input  logic [mipsPkg::DATA_W-1:0] fwdData,
  output logic [mipsPkg::REG_W-1:0]  regAddrA,
  output logic [mipsPkg::REG_W-1:0]  regAddrB,
  output logic                       exValid,
  output logic                       exRegWrite,
  output logic                       exMemToReg,
  output logic [mipsPkg::REG_W-1:0]  exDestReg,
  output logic [mipsPkg::DATA_W-1:0] exAlu,
  output logic [mipsPkg::DATA_W-1:0] exLoad,
  output logic                       exStoreEn,
  output logic [mipsPkg::DATA_W-1:0] exStoreAddr,
  output logic [mipsPkg::DATA_W-1:0] exStoreData,
  output logic                       exRedirect,
  output logic [mipsPkg::DATA_W-1:0] exRedirectPc
);
  import mipsPkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [DATA_W-1:0] exWbData;
  logic [DATA_W-1:0] opA;
  logic [DATA_W-1:0] opB;
  logic [DATA_W-1:0] immExt;
  logic [DATA_W-1:0] aluB;
  logic [DATA_W-1:0] aluOut;
  logic [DATA_W-1:0] pcPlus4;
  logic [DATA_W-1:0] loadData;
  logic [DATA_W-1:0] nextPc;
  logic              taken;

  assign regAddrA = rs;
  assign regAddrB = rt;

  // *******************************************************************
  // Operand bypass
  // *******************************************************************
  // The instruction one ahead still sits in this stage's registers and wins
  // over the one in the result stage
  assign exWbData = exMemToReg ? exLoad : exAlu;

  assign opA = (exRegWrite && exDestReg != '0 && exDestReg == rs) ? exWbData :
               (fwdEn && fwdReg != '0 && fwdReg == rs)             ? fwdData  : rdDataA;
  assign opB = (exRegWrite && exDestReg != '0 && exDestReg == rt) ? exWbData :
               (fwdEn && fwdReg != '0 && fwdReg == rt)             ? fwdData  : rdDataB;

  // *******************************************************************
  // ALU, branch and jump
  // *******************************************************************
  assign immExt = zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
  assign aluB   = aluSrc ? immExt : opB;

  always_comb begin
    case (aluControl)
      aluAdd: aluOut = opA + aluB;
      aluSub: aluOut = opA - aluB;
      aluSlt: aluOut = {{(DATA_W-1){1'b0}}, ($signed(opA) < $signed(aluB))};
      aluXor: aluOut = opA ^ aluB;
    endcase
  end

  assign pcPlus4 = decPc + 32'd4;
  assign taken   = branch && (opA != opB);

  always_comb begin
    if (jumpReg) begin
      nextPc = opA;
    end else if (jump) begin
      nextPc = {pcPlus4[31:28], target, 2'b00};
    end else begin
      nextPc = pcPlus4 + {immExt[DATA_W-3:0], 2'b00};  // bne offset in words
    end
  end

  dataMem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) uDataMem (
    .clk    (clk),
    .we     (memWrite),
    .addr   (aluOut[2 +: IDX_W]),
    .wrData (opB),
    .rdData (loadData)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exValid    <= 1'b0;
      exRegWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exStoreEn  <= 1'b0;
      exRedirect <= 1'b0;
    end else begin
      exValid    <= decValid;
      exRegWrite <= regWrite;
      exMemToReg <= memToReg;
      exStoreEn  <= memWrite;
      exRedirect <= jump | jumpReg | taken;
    end
  end

  always_ff @(posedge clk) begin
    exDestReg    <= destReg;
    exAlu        <= link ? pcPlus4 : aluOut;  // jal links pc+4
    exLoad       <= loadData;
    exStoreAddr  <= aluOut;
    exStoreData  <= opB;
    exRedirectPc <= nextPc;
  end

endmodule

`default_nettype wire

//--- hw/resultStage.sv
`timescale 1ns/1ns
`default_nettype none

module resultStage (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       exValid,
  input  logic                       exRegWrite,
  input  logic                       exMemToReg,
  input  logic [mipsPkg::REG_W-1:0]  exDestReg,
  input  logic [mipsPkg::DATA_W-1:0] exAlu,
  input  logic [mipsPkg::DATA_W-1:0] exLoad,
  input  logic                       exStoreEn,
  input  logic [mipsPkg::DATA_W-1:0] exStoreAddr,
  input  logic [mipsPkg::DATA_W-1:0] exStoreData,
  input  logic                       exRedirect,
  input  logic [mipsPkg::DATA_W-1:0] exRedirectPc,
  output logic                       retireValid,
  output logic                       wbEn,
  output logic [mipsPkg::REG_W-1:0]  wbReg,
  output logic [mipsPkg::DATA_W-1:0] wbData,
  output logic                       storeEn,
  output logic [mipsPkg::DATA_W-1:0] storeAddr,
  output logic [mipsPkg::DATA_W-1:0] storeData,
  output logic                       redirect,
  output logic [mipsPkg::DATA_W-1:0] redirectPc
);

  // Retire register, also the source of the write port and the bypass
  always_ff @(posedge clk) begin
    if (!rstN) begin
      retireValid <= 1'b0;
      wbEn        <= 1'b0;
      storeEn     <= 1'b0;
      redirect    <= 1'b0;
    end else begin
      retireValid <= exValid;
      wbEn        <= exRegWrite;
      storeEn     <= exStoreEn;
      redirect    <= exRedirect;
    end
  end

  always_ff @(posedge clk) begin
    wbReg      <= exDestReg;
    wbData     <= exMemToReg ? exLoad : exAlu;
    storeAddr  <= exStoreAddr;
    storeData  <= exStoreData;
    redirectPc <= exRedirectPc;
  end

endmodule

`default_nettype wire

//--- hw/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       instrValid,
  input  logic [31:0]                instr,
  input  logic [31:0]                pc,
  output logic                       retireValid,
  output logic                       wbEn,
  output logic [mipsPkg::REG_W-1:0]  wbReg,
  output logic [mipsPkg::DATA_W-1:0] wbData,
  output logic                       storeEn,
  output logic [mipsPkg::DATA_W-1:0] storeAddr,
  output logic [mipsPkg::DATA_W-1:0] storeData,
  output logic                       redirect,
  output logic [mipsPkg::DATA_W-1:0] redirectPc
);
  import mipsPkg::*;

  // *******************************************************************
  // Decode to execute
  // *******************************************************************
  logic             decValid;
  logic             regWrite;
  logic             memToReg;
  logic             memWrite;
  logic             branch;
  logic             jump;
  logic             jumpReg;
  logic             link;
  logic             aluSrc;
  logic             zeroExt;
  aluOpT            aluControl;
  logic [REG_W-1:0] rs;
  logic [REG_W-1:0] rt;
  logic [REG_W-1:0] destReg;
  logic [15:0]      imm;
  logic [25:0]      target;
  logic [31:0]      decPc;

  // Register file read side
  logic [REG_W-1:0]  regAddrA;
  logic [REG_W-1:0]  regAddrB;
  logic [DATA_W-1:0] rdDataA;
  logic [DATA_W-1:0] rdDataB;

  // *******************************************************************
  // Execute to result
  // *******************************************************************
  logic              exValid;
  logic              exRegWrite;
  logic              exMemToReg;
  logic [REG_W-1:0]  exDestReg;
  logic [DATA_W-1:0] exAlu;
  logic [DATA_W-1:0] exLoad;
  logic              exStoreEn;
  logic [DATA_W-1:0] exStoreAddr;
  logic [DATA_W-1:0] exStoreData;
  logic              exRedirect;
  logic [DATA_W-1:0] exRedirectPc;

  controlUnit uControl (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .decValid   (decValid),
    .regWrite   (regWrite),
    .memToReg   (memToReg),
    .memWrite   (memWrite),
    .branch     (branch),
    .jump       (jump),
    .jumpReg    (jumpReg),
    .link       (link),
    .aluSrc     (aluSrc),
    .zeroExt    (zeroExt),
    .aluControl (aluControl),
    .rs         (rs),
    .rt         (rt),
    .destReg    (destReg),
    .imm        (imm),
    .target     (target),
    .decPc      (decPc)
  );

  executeUnit #(
    .DMEM_WORDS (DMEM_WORDS)
  ) uExecute (
    .clk          (clk),
    .rstN         (rstN),
    .decValid     (decValid),
    .regWrite     (regWrite),
    .memToReg     (memToReg),
    .memWrite     (memWrite),
    .branch       (branch),
    .jump         (jump),
    .jumpReg      (jumpReg),
    .link         (link),
    .aluSrc       (aluSrc),
    .zeroExt      (zeroExt),
    .aluControl   (aluControl),
    .rs           (rs),
    .rt           (rt),
    .destReg      (destReg),
    .imm          (imm),
    .target       (target),
    .decPc        (decPc),
    .rdDataA      (rdDataA),
    .rdDataB      (rdDataB),
    .fwdEn        (wbEn),          // Result stage bypass
    .fwdReg       (wbReg),
    .fwdData      (wbData),
    .regAddrA     (regAddrA),
    .regAddrB     (regAddrB),
    .exValid      (exValid),
    .exRegWrite   (exRegWrite),
    .exMemToReg   (exMemToReg),
    .exDestReg    (exDestReg),
    .exAlu        (exAlu),
    .exLoad       (exLoad),
    .exStoreEn    (exStoreEn),
    .exStoreAddr  (exStoreAddr),
    .exStoreData  (exStoreData),
    .exRedirect   (exRedirect),
    .exRedirectPc (exRedirectPc)
  );

  regFile uRegFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (regAddrA),
    .rdAddrB (regAddrB),
    .wrEn    (wbEn),
    .wrAddr  (wbReg),
    .wrData  (wbData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  resultStage uResult (
    .clk          (clk),
    .rstN         (rstN),
    .exValid      (exValid),
    .exRegWrite   (exRegWrite),
    .exMemToReg   (exMemToReg),
    .exDestReg    (exDestReg),
    .exAlu        (exAlu),
    .exLoad       (exLoad),
    .exStoreEn    (exStoreEn),
    .exStoreAddr  (exStoreAddr),
    .exStoreData  (exStoreData),
    .exRedirect   (exRedirect),
    .exRedirectPc (exRedirectPc),
    .retireValid  (retireValid),
    .wbEn         (wbEn),
    .wbReg        (wbReg),
    .wbData       (wbData),
    .storeEn      (storeEn),
    .storeAddr    (storeAddr),
    .storeData    (storeData),
    .redirect     (redirect),
    .redirectPc   (redirectPc)
  );

endmodule

`default_nettype wire

//--- test/coreChecker.sv
`timescale 1ns/1ns
`default_nettype none

module coreChecker (
  input logic                       clk,
  input logic                       rstN,
  input logic                       retireValid,
  input logic                       wbEn,
  input logic [mipsPkg::REG_W-1:0]  wbReg,
  input logic [mipsPkg::DATA_W-1:0] wbData,
  input logic                       storeEn,
  input logic [mipsPkg::DATA_W-1:0] storeAddr,
  input logic [mipsPkg::DATA_W-1:0] storeData,
  input logic                       redirect,
  input logic [mipsPkg::DATA_W-1:0] redirectPc
);

  typedef struct packed {
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        storeEn;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    logic        redirect;
    logic [31:0] redirectPc;
    logic [31:0] acceptCycle;  // Edge count at which the DUT sampled the instruction
  } retireT;

  retireT      expQ[$];
  string       nameQ[$];
  retireT      head;
  string       headName;
  int unsigned cycle = 0;
  int          testCount = 0;
  int          failCount = 0;
  int          errorCount = 0;
  int          quietFaults = 0;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic pushExpected(input string name, input logic wantWbEn,
                              input logic [4:0] wantWbReg, input logic [31:0] wantWbData,
                              input logic wantStoreEn, input logic [31:0] wantStoreAddr,
                              input logic [31:0] wantStoreData, input logic wantRedirect,
                              input logic [31:0] wantRedirectPc);
    retireT e;
    e = {wantWbEn, wantWbReg, wantWbData, wantStoreEn, wantStoreAddr, wantStoreData,
         wantRedirect, wantRedirectPc, cycle + 32'd1};
    expQ.push_back(e);
    nameQ.push_back(name);
  endtask

  function automatic int pending();
    return expQ.size();
  endfunction

  function automatic int checkField(input string sig, input logic [31:0] got,
                                    input logic [31:0] want);
    if (got !== want) begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h", sig, got, want);
      return 1;
    end
    return 0;
  endfunction

  task automatic compareRetire(input retireT e, input string name);
    int errs;
    errs = 0;
    if (cycle != e.acceptCycle + 2) begin
      $display("Retire of %s came %0d cycles after it was accepted, not 2",
               name, cycle - e.acceptCycle);
      errs++;
    end
    errs += checkField("wbEn", wbEn, e.wbEn);
    if (e.wbEn) begin  // Destination only matters when a write is expected
      errs += checkField("wbReg", wbReg, e.wbReg);
      errs += checkField("wbData", wbData, e.wbData);
    end
    errs += checkField("storeEn", storeEn, e.storeEn);
    if (e.storeEn) begin
      errs += checkField("storeAddr", storeAddr, e.storeAddr);
      errs += checkField("storeData", storeData, e.storeData);
    end
    errs += checkField("redirect", redirect, e.redirect);
    if (e.redirect) errs += checkField("redirectPc", redirectPc, e.redirectPc);
    testCount++;
    errorCount += errs;
    if (errs == 0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s", name);
      failCount++;
    end
  endtask

  task automatic reportQuiet(input string name);
    testCount++;
    if (quietFaults == 0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s", name);
      failCount++;
    end
    quietFaults = 0;
  endtask

  // ******************************************************************
  // Retire monitor, sampled on the falling edge where outputs are stable
  // ******************************************************************
  always @(negedge clk) begin
    if (rstN) begin
      if (retireValid) begin
        if (expQ.size() == 0) begin
          $display("A retire appeared at cycle %0d with no instruction outstanding", cycle);
          errorCount++;
          failCount++;
        end else begin
          head = expQ.pop_front();
          headName = nameQ.pop_front();
          compareRetire(head, headName);
        end
      end else if (wbEn || storeEn || redirect) begin
        $display("ERROR wbEn/storeEn/redirect without retire: 0x%0h 0x%0h 0x%0h",
                 wbEn, storeEn, redirect);
        errorCount++;
        quietFaults++;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tbMipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module tbMipsCore;
  import mipsPkg::*;

  localparam int          DMEM_WORDS  = 64;
  localparam logic [31:0] PC_BASE     = 32'h0040_0000;
  localparam int          DRAIN_LIMIT = 20;

  typedef struct packed {
    logic [3:0]  gap;  // Idle cycles before this instruction
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        storeEn;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    logic        redirect;
    logic [31:0] redirectPc;
  } stepT;

  logic              clk;
  logic              rstN;
  logic              instrValid;
  logic [31:0]       instr;
  logic [31:0]       pc;
  logic              retireValid;
  logic              wbEn;
  logic [REG_W-1:0]  wbReg;
  logic [DATA_W-1:0] wbData;
  logic              storeEn;
  logic [DATA_W-1:0] storeAddr;
  logic [DATA_W-1:0] storeData;
  logic              redirect;
  logic [DATA_W-1:0] redirectPc;

  stepT  steps[$];
  string stepNames[$];
  int    nextGap;
  int    drainCycles;
  logic  timedOut;

  mipsCore #(
    .DMEM_WORDS (DMEM_WORDS)
  ) mipsCore_inst (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .pc          (pc),
    .retireValid (retireValid),
    .wbEn        (wbEn),
    .wbReg       (wbReg),
    .wbData      (wbData),
    .storeEn     (storeEn),
    .storeAddr   (storeAddr),
    .storeData   (storeData),
    .redirect    (redirect),
    .redirectPc  (redirectPc)
  );

  coreChecker checkerInst (
    .clk         (clk),
    .rstN        (rstN),
    .retireValid (retireValid),
    .wbEn        (wbEn),
    .wbReg       (wbReg),
    .wbData      (wbData),
    .storeEn     (storeEn),
    .storeAddr   (storeAddr),
    .storeData   (storeData),
    .redirect    (redirect),
    .redirectPc  (redirectPc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  // ******************************************************************
  // Stimulus and expected-value table
  // ******************************************************************
  task automatic addStep(input string name, input logic [31:0] word, input logic we,
                         input logic [4:0] rd, input logic [31:0] wd, input logic se,
                         input logic [31:0] sa, input logic [31:0] sd, input logic re,
                         input logic [31:0] rp);
    stepT s;
    s = {4'(nextGap), word, PC_BASE + 32'(4 * steps.size()), we, rd, wd, se, sa, sd, re, rp};
    steps.push_back(s);
    stepNames.push_back(name);
    nextGap = 0;
  endtask

  task automatic addWrite(input string name, input logic [31:0] word, input logic [4:0] rd,
                          input logic [31:0] wd);
    addStep(name, word, 1'b1, rd, wd, 1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic addStore(input string name, input logic [31:0] word, input logic [31:0] sa,
                          input logic [31:0] sd);
    addStep(name, word, 1'b0, '0, '0, 1'b1, sa, sd, 1'b0, '0);
  endtask

  task automatic addRedirect(input string name, input logic [31:0] word,
                             input logic [31:0] rp);
    addStep(name, word, 1'b0, '0, '0, 1'b0, '0, '0, 1'b1, rp);
  endtask

  task automatic addNop(input string name, input logic [31:0] word);
    addStep(name, word, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
  endtask

  // Instruction i sits at PC_BASE + 4*i, which fixes the branch and jump targets below
  task automatic buildTable();
    addWrite("xori r1,r0,0x5", iType(opXori, 0, 1, 16'h0005), 1, 32'h0000_0005);
    addWrite("xori r2,r0,0x8001", iType(opXori, 0, 2, 16'h8001), 2, 32'h0000_8001);
    addWrite("xori r3,r0,0xffff", iType(opXori, 0, 3, 16'hFFFF), 3, 32'h0000_FFFF);
    addWrite("add r4,r1,r2", rType(fnAdd, 1, 2, 4), 4, 32'h0000_8006);
    addWrite("sub r5,r0,r1", rType(fnSub, 0, 1, 5), 5, 32'hFFFF_FFFB);
    addWrite("slt r6,r5,r1", rType(fnSlt, 5, 1, 6), 6, 32'h0000_0001);
    addWrite("slt r7,r1,r5", rType(fnSlt, 1, 5, 7), 7, 32'h0000_0000);
    addWrite("sub r8,r5,r2", rType(fnSub, 5, 2, 8), 8, 32'hFFFF_7FFA);
    addWrite("slt r9,r8,r5", rType(fnSlt, 8, 5, 9), 9, 32'h0000_0001);
    addWrite("xori r0,r1,0xff", iType(opXori, 1, 0, 16'h00FF), 0, 32'h0000_00FA);
    addWrite("add r10,r0,r1", rType(fnAdd, 0, 1, 10), 10, 32'h0000_0005);
    nextGap = 2;  // Dependent chain, each one needs the previous result
    addWrite("add r11,r1,r1", rType(fnAdd, 1, 1, 11), 11, 32'h0000_000A);
    addWrite("add r12,r11,r11", rType(fnAdd, 11, 11, 12), 12, 32'h0000_0014);
    addWrite("sub r13,r12,r11", rType(fnSub, 12, 11, 13), 13, 32'h0000_000A);
    addWrite("xori r14,r13,0xf0f", iType(opXori, 13, 14, 16'h0F0F), 14, 32'h0000_0F05);
    addWrite("slt r15,r14,r13", rType(fnSlt, 14, 13, 15), 15, 32'h0000_0000);
    nextGap = 2;
    addWrite("xori r16,r0,0x40", iType(opXori, 0, 16, 16'h0040), 16, 32'h0000_0040);
    addStore("sw r8,8(r16)", iType(opSw, 16, 8, 16'h0008), 32'h48, 32'hFFFF_7FFA);
    addStore("sw r14,-4(r16)", iType(opSw, 16, 14, 16'hFFFC), 32'h3C, 32'h0000_0F05);
    addWrite("lw r17,8(r16)", iType(opLw, 16, 17, 16'h0008), 17, 32'hFFFF_7FFA);
    addWrite("lw r18,0x13c(r0)", iType(opLw, 0, 18, 16'h013C), 18, 32'h0000_0F05);
    addWrite("add r19,r17,r18", rType(fnAdd, 17, 18, 19), 19, 32'hFFFF_8EFF);
    nextGap = 2;
    addNop("bne r1,r10 equal", iType(opBne, 1, 10, 16'h0010));
    addRedirect("bne r1,r2 forward", iType(opBne, 1, 2, 16'h0010), 32'h0040_00A0);
    addRedirect("bne r5,r0 backward", iType(opBne, 5, 0, 16'hFFF8), 32'h0040_0044);
    addRedirect("j 0x0100040", jType(opJ, 26'h010_0040), 32'h0040_0100);
    addStep("jal 0x0100080", jType(opJal, 26'h010_0080), 1'b1, 31, 32'h0040_006C,
            1'b0, '0, '0, 1'b1, 32'h0040_0200);
    addRedirect("jr r31", rType(fnJr, 31, 0, 0), 32'h0040_006C);
    addWrite("add r20,r31,r0", rType(fnAdd, 31, 0, 20), 20, 32'h0040_006C);
    nextGap = 2;
    addNop("unknown opcode 0x3f", 32'hFC21_0001);
    addNop("unknown funct 0x25", rType(6'h25, 1, 2, 3));
    addNop("unsupported ori r1", iType(6'h0D, 1, 1, 16'hFFFF));
    addWrite("add r21,r1,r0", rType(fnAdd, 1, 0, 21), 21, 32'h0000_0005);
  endtask

  initial begin
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    nextGap    = 0;
    timedOut   = 1'b0;
    buildTable();
    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;
    repeat (10) @(negedge clk);
    #1 checkerInst.reportQuiet("idle after reset");

    for (int i = 0; i < steps.size(); i++) begin
      repeat (steps[i].gap) begin
        @(posedge clk);
        #1 instrValid = 1'b0;
      end
      @(posedge clk);
      #1;
      instrValid = 1'b1;
      instr      = steps[i].instr;
      pc         = steps[i].pc;
      checkerInst.pushExpected(stepNames[i], steps[i].wbEn, steps[i].wbReg, steps[i].wbData,
                               steps[i].storeEn, steps[i].storeAddr, steps[i].storeData,
                               steps[i].redirect, steps[i].redirectPc);
    end
    @(posedge clk);
    #1 instrValid = 1'b0;

    drainCycles = 0;
    while (checkerInst.pending() != 0 && drainCycles < DRAIN_LIMIT) begin
      @(posedge clk);
      drainCycles++;
    end
    if (checkerInst.pending() != 0) begin
      timedOut = 1'b1;
      $display("Timed out after %0d cycles with %0d retires still outstanding",
               drainCycles, checkerInst.pending());
    end
    repeat (4) @(posedge clk);  // Catch any stray retire after the last one
    #1;
    $display("Summary: %0d tests, %0d failed, %0d errors", checkerInst.testCount,
             checkerInst.failCount, checkerInst.errorCount);
    if (!timedOut && checkerInst.failCount == 0 && checkerInst.errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/mipsPkg.sv
hw/controlUnit.sv
hw/regFile.sv
hw/dataMem.sv
hw/executeUnit.sv
hw/resultStage.sv
hw/mipsCore.sv
test/coreChecker.sv
test/tbMipsCore.sv
